//--- design/alu_decoder.sv
// alu decoder, alu class plus funct3 and funct7[5] to the 5-bit alu control code
`timescale 1ns/1ps

module alu_decoder
    import osiris_decode_pkg::*;
(
    input  alu_class_t   i_alu_class,
    input  logic [2:0]   i_funct_3,
    input  logic         i_funct_7_5,   // sub / sra select
    output alu_control_t o_alu_control
);

    always_comb begin
        o_alu_control = ALUC_ADD;
        case (i_alu_class)
            ALU_CLASS_ADD_SUB: o_alu_control = i_funct_7_5 ? ALUC_SUB : ALUC_ADD;

            ALU_CLASS_ARITH: begin
                // op-imm never reaches sub, its funct3 000 is always addi
                case (i_funct_3)
                    3'b000:  o_alu_control = ALUC_ADD;
                    3'b001:  o_alu_control = ALUC_SLL;
                    3'b010:  o_alu_control = ALUC_SLT;
                    3'b011:  o_alu_control = ALUC_SLTU;
                    3'b100:  o_alu_control = ALUC_XOR;
                    3'b101:  o_alu_control = i_funct_7_5 ? ALUC_SRA : ALUC_SRL;
                    3'b110:  o_alu_control = ALUC_OR;
                    default: o_alu_control = ALUC_AND;  // 111
                endcase
            end

            ALU_CLASS_BRANCH: begin
                case (i_funct_3)
                    3'b001:  o_alu_control = ALUC_BNE;
                    3'b100:  o_alu_control = ALUC_BLT;
                    3'b101:  o_alu_control = ALUC_BGE;
                    3'b110:  o_alu_control = ALUC_BLTU;
                    3'b111:  o_alu_control = ALUC_BGEU;
                    default: o_alu_control = ALUC_BEQ;  // 000 and the reserved 010/011
                endcase
            end

            ALU_CLASS_LUI: o_alu_control = ALUC_LUI;
            default:       o_alu_control = ALUC_ADD;    // add class, addresses and auipc
        endcase
    end

endmodule

//--- design/decode_stage.sv
// decode stage top, field slicing and wiring of decoders, register file and id/ex register
`timescale 1ns/1ps

module decode_stage
    import osiris_decode_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  logic         i_clk,
    input  logic         i_reset,
    input  word_t        i_instr_ID,
    input  word_t        i_pc_ID,
    input  logic         i_stall,
    input  logic         i_flush,
    input  logic         i_wb_reg_write,  // write-back port
    input  reg_addr_t    i_wb_rd,
    input  word_t        i_wb_result,
    output logic         o_jump_EX,
    output logic         o_branch_EX,
    output logic         o_reg_write_EX,
    output logic         o_mem_write_EX,
    output logic         o_alu_src_EX,
    output logic         o_addr_src_EX,
    output logic         o_fence_EX,
    output result_src_t  o_result_src_EX,
    output alu_control_t o_alu_control_EX,
    output word_t        o_rd1_EX,
    output word_t        o_rd2_EX,
    output word_t        o_imm_ext_EX,
    output word_t        o_pc_EX,
    output reg_addr_t    o_rd_EX,
    output logic [2:0]   o_funct_3_EX
);

    // ------------------------------------------------------------------
    // instruction fields
    // ------------------------------------------------------------------
    opcode_t    opcode;
    logic [2:0] funct_3;
    logic       funct_7_5;
    reg_addr_t  rs1, rs2, rd;

    assign opcode    = i_instr_ID[6:2];   // bits 1:0 ignored
    assign funct_3   = i_instr_ID[14:12];
    assign funct_7_5 = i_instr_ID[30];
    assign rs1       = i_instr_ID[19:15];
    assign rs2       = i_instr_ID[24:20];
    assign rd        = i_instr_ID[11:7];

    // decoded controls and operands
    logic         jump, branch, reg_write, mem_write;
    logic         alu_src, addr_src, fence;
    result_src_t  result_src;
    imm_src_t     imm_src;
    alu_class_t   alu_class;
    alu_control_t alu_control;
    word_t        imm_ext, rd1, rd2;

    op_decoder u_op_decoder (
        .i_op(opcode), .i_funct_3(funct_3),
        .o_jump_ID(jump), .o_branch_ID(branch), .o_reg_write_ID(reg_write),
        .o_mem_write_ID(mem_write), .o_alu_src_ID(alu_src), .o_addr_src_ID(addr_src),
        .o_fence_ID(fence), .o_result_src_ID(result_src), .o_imm_src_ID(imm_src),
        .o_alu_class(alu_class)
    );

    alu_decoder u_alu_decoder (
        .i_alu_class(alu_class), .i_funct_3(funct_3), .i_funct_7_5(funct_7_5),
        .o_alu_control(alu_control)
    );

    imm_extend u_imm_extend (
        .i_instr(i_instr_ID), .i_imm_src(imm_src), .o_imm_ext(imm_ext)
    );

    // operand path, in parallel with the decoders
    register_file #(.NUM_REGS(NUM_REGS)) u_register_file (
        .i_clk(i_clk), .i_reset(i_reset), .i_rs1(rs1), .i_rs2(rs2),
        .i_we(i_wb_reg_write), .i_rd(i_wb_rd), .i_wd(i_wb_result),
        .o_rd1(rd1), .o_rd2(rd2)
    );

    id_ex_register u_id_ex_register (
        .i_clk(i_clk), .i_reset(i_reset), .i_stall(i_stall), .i_flush(i_flush),
        .i_jump_ID(jump), .i_branch_ID(branch), .i_reg_write_ID(reg_write),
        .i_mem_write_ID(mem_write), .i_alu_src_ID(alu_src), .i_addr_src_ID(addr_src),
        .i_fence_ID(fence), .i_result_src_ID(result_src), .i_alu_control(alu_control),
        .i_rd1(rd1), .i_rd2(rd2), .i_imm_ext(imm_ext), .i_pc(i_pc_ID), .i_rd(rd),
        .i_funct_3(funct_3),
        .o_jump_EX(o_jump_EX), .o_branch_EX(o_branch_EX),
        .o_reg_write_EX(o_reg_write_EX), .o_mem_write_EX(o_mem_write_EX),
        .o_alu_src_EX(o_alu_src_EX), .o_addr_src_EX(o_addr_src_EX),
        .o_fence_EX(o_fence_EX), .o_result_src_EX(o_result_src_EX),
        .o_alu_control_EX(o_alu_control_EX), .o_rd1_EX(o_rd1_EX), .o_rd2_EX(o_rd2_EX),
        .o_imm_ext_EX(o_imm_ext_EX), .o_pc_EX(o_pc_EX), .o_rd_EX(o_rd_EX),
        .o_funct_3_EX(o_funct_3_EX)
    );

endmodule

//--- design/id_ex_register.sv
// id/ex pipeline register with reset, stall hold, flush bubble and checks
`timescale 1ns/1ps

module id_ex_register
    import osiris_decode_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_reset,
    input  logic         i_stall,          // hold current entry
    input  logic         i_flush,          // insert bubble, wins over stall
    // control path
    input  logic         i_jump_ID,
    input  logic         i_branch_ID,
    input  logic         i_reg_write_ID,
    input  logic         i_mem_write_ID,
    input  logic         i_alu_src_ID,
    input  logic         i_addr_src_ID,
    input  logic         i_fence_ID,
    input  result_src_t  i_result_src_ID,
    input  alu_control_t i_alu_control,
    // operand path
    input  word_t        i_rd1,
    input  word_t        i_rd2,
    input  word_t        i_imm_ext,
    input  word_t        i_pc,
    input  reg_addr_t    i_rd,
    input  logic [2:0]   i_funct_3,        // load/store width downstream
    // ex side
    output logic         o_jump_EX,
    output logic         o_branch_EX,
    output logic         o_reg_write_EX,
    output logic         o_mem_write_EX,
    output logic         o_alu_src_EX,
    output logic         o_addr_src_EX,
    output logic         o_fence_EX,
    output result_src_t  o_result_src_EX,
    output alu_control_t o_alu_control_EX,
    output word_t        o_rd1_EX,
    output word_t        o_rd2_EX,
    output word_t        o_imm_ext_EX,
    output word_t        o_pc_EX,
    output reg_addr_t    o_rd_EX,
    output logic [2:0]   o_funct_3_EX
);

    always_ff @(posedge i_clk) begin
        if (i_reset || i_flush) begin  // bubble, data cleared as well
            o_jump_EX        <= 1'b0;
            o_branch_EX      <= 1'b0;
            o_reg_write_EX   <= 1'b0;
            o_mem_write_EX   <= 1'b0;
            o_alu_src_EX     <= 1'b0;
            o_addr_src_EX    <= 1'b0;
            o_fence_EX       <= 1'b0;
            o_result_src_EX  <= RES_ALU;
            o_alu_control_EX <= ALUC_AND;  // code 0
            o_rd1_EX         <= '0;
            o_rd2_EX         <= '0;
            o_imm_ext_EX     <= '0;
            o_pc_EX          <= '0;
            o_rd_EX          <= '0;
            o_funct_3_EX     <= '0;
        end else if (!i_stall) begin
            o_jump_EX        <= i_jump_ID;
            o_branch_EX      <= i_branch_ID;
            o_reg_write_EX   <= i_reg_write_ID;
            o_mem_write_EX   <= i_mem_write_ID;
            o_alu_src_EX     <= i_alu_src_ID;
            o_addr_src_EX    <= i_addr_src_ID;
            o_fence_EX       <= i_fence_ID;
            o_result_src_EX  <= i_result_src_ID;
            o_alu_control_EX <= i_alu_control;
            o_rd1_EX         <= i_rd1;
            o_rd2_EX         <= i_rd2;
            o_imm_ext_EX     <= i_imm_ext;
            o_pc_EX          <= i_pc;
            o_rd_EX          <= i_rd;
            o_funct_3_EX     <= i_funct_3;
        end
        // stall: everything holds
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    // a flushed slot must not write anything back
    a_flush_bubble: assert property (@(posedge i_clk) disable iff (i_reset)
        i_flush |=> (!o_reg_write_EX && !o_mem_write_EX));

    // decoder never marks one instruction as two kinds of flow change
    a_ctrl_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
        $onehot0({o_jump_EX, o_branch_EX, o_mem_write_EX}));

    a_stall_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_stall && !i_flush) |=> $stable({o_jump_EX, o_branch_EX, o_reg_write_EX,
            o_mem_write_EX, o_alu_src_EX, o_addr_src_EX, o_fence_EX, o_result_src_EX,
            o_alu_control_EX, o_rd1_EX, o_rd2_EX, o_imm_ext_EX, o_pc_EX, o_rd_EX,
            o_funct_3_EX}));

endmodule

//--- design/imm_extend.sv
// immediate generator for the i, s, b, j and u formats
`timescale 1ns/1ps

module imm_extend
    import osiris_decode_pkg::*;
(
    input  word_t    i_instr,
    input  imm_src_t i_imm_src,
    output word_t    o_imm_ext
);

    logic sign;  // every format takes its sign from bit 31

    assign sign = i_instr[31];

    always_comb begin
        case (i_imm_src)
            IMM_I: o_imm_ext = {{20{sign}}, i_instr[31:20]};
            IMM_S: o_imm_ext = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
            // b and j are halfword offsets, lsb forced to zero
            IMM_B: o_imm_ext = {{19{sign}}, sign, i_instr[7], i_instr[30:25],
                                i_instr[11:8], 1'b0};
            IMM_J: o_imm_ext = {{11{sign}}, sign, i_instr[19:12], i_instr[20],
                                i_instr[30:21], 1'b0};
            IMM_U: o_imm_ext = {i_instr[31:12], 12'b0};  // no extension needed
            default: o_imm_ext = '0;
        endcase
    end

endmodule

//--- design/op_decoder.sv
// main decoder, opcode to control bits, immediate format and alu class
`timescale 1ns/1ps

module op_decoder
    import osiris_decode_pkg::*;
(
    input  opcode_t     i_op,
    input  logic [2:0]  i_funct_3,       // only needed to split add/sub from other r-type
    output logic        o_jump_ID,
    output logic        o_branch_ID,
    output logic        o_reg_write_ID,
    output logic        o_mem_write_ID,
    output logic        o_alu_src_ID,    // 1: operand b from immediate
    output logic        o_addr_src_ID,   // 1: jump target from rs1 (jalr)
    output logic        o_fence_ID,
    output result_src_t o_result_src_ID,
    output imm_src_t    o_imm_src_ID,
    output alu_class_t  o_alu_class
);

    always_comb begin
        // defaults cover unknown opcodes, decoded as a harmless add
        o_jump_ID       = 1'b0;
        o_branch_ID     = 1'b0;
        o_reg_write_ID  = 1'b0;
        o_mem_write_ID  = 1'b0;
        o_alu_src_ID    = 1'b0;
        o_addr_src_ID   = 1'b0;
        o_fence_ID      = 1'b0;
        o_result_src_ID = RES_ALU;
        o_imm_src_ID    = IMM_I;
        o_alu_class     = ALU_CLASS_ADD;

        case (i_op)
            LUI: begin
                o_reg_write_ID = 1'b1;
                o_alu_src_ID   = 1'b1;
                o_imm_src_ID   = IMM_U;
                o_alu_class    = ALU_CLASS_LUI;
            end
            AUIPC: begin
                o_reg_write_ID  = 1'b1;
                o_alu_src_ID    = 1'b1;
                o_imm_src_ID    = IMM_U;
                o_result_src_ID = RES_PC_IMM; // pc + upper imm
            end
            JAL: begin
                o_jump_ID       = 1'b1;
                o_reg_write_ID  = 1'b1;
                o_imm_src_ID    = IMM_J;
                o_result_src_ID = RES_PC4;    // rd gets link address
            end
            JALR: begin
                o_reg_write_ID  = 1'b1;
                o_alu_src_ID    = 1'b1;
                o_addr_src_ID   = 1'b1;       // target = rs1 + imm
                o_result_src_ID = RES_PC4;
            end
            LOAD: begin
                o_reg_write_ID  = 1'b1;
                o_alu_src_ID    = 1'b1;
                o_result_src_ID = RES_MEM;
            end
            STORE: begin
                o_mem_write_ID = 1'b1;
                o_alu_src_ID   = 1'b1;
                o_imm_src_ID   = IMM_S;
            end
            OP_IMM: begin
                o_reg_write_ID = 1'b1;
                o_alu_src_ID   = 1'b1;
                o_alu_class    = ALU_CLASS_ARITH;
            end
            OP: begin
                o_reg_write_ID = 1'b1;
                o_alu_class    = (i_funct_3 == 3'b000) ? ALU_CLASS_ADD_SUB : ALU_CLASS_ARITH;
            end
            BRANCH: begin
                o_branch_ID  = 1'b1;
                o_imm_src_ID = IMM_B;
                o_alu_class  = ALU_CLASS_BRANCH;
            end
            FENCE:  o_fence_ID = 1'b1;       // flag only, no ordering effect
            SYSTEM: begin
                o_reg_write_ID = 1'b1;       // ecall/ebreak run as addi
                o_alu_src_ID   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- design/osiris_decode_pkg.sv
// width types, opcode constants, alu class and control codes, immediate and result selects
package osiris_decode_pkg;

    // ------------------------------------------------------------------
    // width types
    // ------------------------------------------------------------------
    typedef logic [31:0] word_t;        // data word or instruction
    typedef logic [4:0]  reg_addr_t;    // register index
    typedef logic [4:0]  opcode_t;      // instr[6:2], low two bits always 11
    typedef logic [2:0]  alu_class_t;   // coarse op class from main decoder
    typedef logic [4:0]  alu_control_t; // code the ALU actually sees
    typedef logic [2:0]  imm_src_t;     // immediate format
    typedef logic [1:0]  result_src_t;  // write-back mux select

    // ------------------------------------------------------------------
    // opcodes, instr[6:2]
    // ------------------------------------------------------------------
    localparam opcode_t LOAD   = 5'b00000;
    localparam opcode_t FENCE  = 5'b00011;
    localparam opcode_t OP_IMM = 5'b00100;
    localparam opcode_t AUIPC  = 5'b00101;
    localparam opcode_t STORE  = 5'b01000;
    localparam opcode_t OP     = 5'b01100;
    localparam opcode_t LUI    = 5'b01101;
    localparam opcode_t BRANCH = 5'b11000;
    localparam opcode_t JALR   = 5'b11001;
    localparam opcode_t JAL    = 5'b11011;
    localparam opcode_t SYSTEM = 5'b11100; // ecall/ebreak, handled as add

    // alu classes
    localparam alu_class_t ALU_CLASS_LUI     = 3'b000;
    localparam alu_class_t ALU_CLASS_ARITH   = 3'b001; // r-type and i-type arithmetic
    localparam alu_class_t ALU_CLASS_ADD_SUB = 3'b010; // r-type funct3 000
    localparam alu_class_t ALU_CLASS_BRANCH  = 3'b011;
    localparam alu_class_t ALU_CLASS_ADD     = 3'b100; // address calc and the rest

    // alu control codes
    localparam alu_control_t ALUC_AND  = 5'd0;
    localparam alu_control_t ALUC_OR   = 5'd1;
    localparam alu_control_t ALUC_XOR  = 5'd2;
    localparam alu_control_t ALUC_ADD  = 5'd3;
    localparam alu_control_t ALUC_SUB  = 5'd4;
    localparam alu_control_t ALUC_SLL  = 5'd5;
    localparam alu_control_t ALUC_SRL  = 5'd6;
    localparam alu_control_t ALUC_SLT  = 5'd7;  // signed
    localparam alu_control_t ALUC_SLTU = 5'd8;
    localparam alu_control_t ALUC_SRA  = 5'd9;
    localparam alu_control_t ALUC_BEQ  = 5'd10;
    localparam alu_control_t ALUC_BNE  = 5'd11;
    localparam alu_control_t ALUC_BLT  = 5'd12;
    localparam alu_control_t ALUC_BLTU = 5'd13;
    localparam alu_control_t ALUC_BGE  = 5'd14;
    localparam alu_control_t ALUC_BGEU = 5'd15;
    localparam alu_control_t ALUC_LUI  = 5'd16; // pass imm through

    // immediate formats
    localparam imm_src_t IMM_I = 3'b000;
    localparam imm_src_t IMM_S = 3'b001;
    localparam imm_src_t IMM_B = 3'b010;
    localparam imm_src_t IMM_J = 3'b011;
    localparam imm_src_t IMM_U = 3'b100;

    // write-back selects
    localparam result_src_t RES_ALU    = 2'b00;
    localparam result_src_t RES_MEM    = 2'b01;
    localparam result_src_t RES_PC4    = 2'b10; // link value for jal/jalr
    localparam result_src_t RES_PC_IMM = 2'b11; // auipc

endpackage

//--- design/register_file.sv
// integer register file, two read ports, one write port, x0 zero, write-through bypass
`timescale 1ns/1ps

module register_file
    import osiris_decode_pkg::*;
#(
    parameter int NUM_REGS = 32  // 16 for rv32e
) (
    input  logic      i_clk,
    input  logic      i_reset,
    input  reg_addr_t i_rs1,
    input  reg_addr_t i_rs2,
    input  logic      i_we,
    input  reg_addr_t i_rd,
    input  word_t     i_wd,
    output word_t     o_rd1,
    output word_t     o_rd2
);

    word_t regs [NUM_REGS];

    logic write_ok;  // real write this cycle

    assign write_ok = i_we && (i_rd != '0) && (i_rd < NUM_REGS);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_ok) begin
            regs[i_rd] <= i_wd;
        end
    end

    // ------------------------------------------------------------------
    // read ports, bypass gives the value being written this cycle
    // ------------------------------------------------------------------
    assign o_rd1 = (i_rs1 == '0 || i_rs1 >= NUM_REGS) ? '0 :    // x0 and holes read 0
                   (write_ok && i_rd == i_rs1)       ? i_wd : regs[i_rs1];
    assign o_rd2 = (i_rs2 == '0 || i_rs2 >= NUM_REGS) ? '0 :
                   (write_ok && i_rd == i_rs2)       ? i_wd : regs[i_rs2];

    // write-back must never address past the implemented file
    a_wr_addr_range: assert property (@(posedge i_clk) disable iff (i_reset)
        i_we |-> (i_rd < NUM_REGS));

    // write lands, visible the cycle after
    a_wr_lands: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_we && i_rd != '0) |=> (regs[$past(i_rd)] == $past(i_wd)));

endmodule

//--- dv/clock_gen.sv
// testbench clock and reset generator
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // synchronous reset, seen by RESET_CYCLES rising edges
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_reset = 1'b0;  // released just after the edge like other stimulus
    end

endmodule

//--- dv/tb_decode_stage.sv
// decode stage testbench with reference model, lcg, compare task, directed tests, watchdog
`timescale 1ns/1ps

module tb_decode_stage
    import osiris_decode_pkg::*;
();

    // reset 3, opcodes 44, alu codes 55, immediates 1000, regfile 73, stall/flush 7
    localparam int TEST_CYCLES = 3 + 44 + 55 + 1000 + 73 + 7;
    localparam int TIMEOUT_NS  = TEST_CYCLES * 100 + 5000;
    localparam opcode_t ALL_OPS [11] = '{LOAD, FENCE, OP_IMM, AUIPC, STORE, OP, LUI,
                                         BRANCH, JALR, JAL, SYSTEM};

    logic clk, reset, stall, flush, wb_we;
    word_t instr, pc, wb_data;
    reg_addr_t wb_rd;
    // ex side of the dut
    logic ex_jump, ex_branch, ex_reg_write, ex_mem_write, ex_alu_src, ex_addr_src, ex_fence;
    result_src_t ex_result_src;
    alu_control_t ex_alu_control;
    word_t ex_rd1, ex_rd2, ex_imm, ex_pc;
    reg_addr_t ex_rd;
    logic [2:0] ex_funct_3;

    word_t lcg_state;
    word_t ref_regs [32];  // model of the register file contents

    clock_gen u_clock_gen (.o_clk(clk), .o_reset(reset));

    decode_stage #(.NUM_REGS(32)) dut (
        .i_clk(clk), .i_reset(reset), .i_instr_ID(instr), .i_pc_ID(pc),
        .i_stall(stall), .i_flush(flush), .i_wb_reg_write(wb_we), .i_wb_rd(wb_rd),
        .i_wb_result(wb_data),
        .o_jump_EX(ex_jump), .o_branch_EX(ex_branch), .o_reg_write_EX(ex_reg_write),
        .o_mem_write_EX(ex_mem_write), .o_alu_src_EX(ex_alu_src),
        .o_addr_src_EX(ex_addr_src), .o_fence_EX(ex_fence),
        .o_result_src_EX(ex_result_src), .o_alu_control_EX(ex_alu_control),
        .o_rd1_EX(ex_rd1), .o_rd2_EX(ex_rd2), .o_imm_ext_EX(ex_imm), .o_pc_EX(ex_pc),
        .o_rd_EX(ex_rd), .o_funct_3_EX(ex_funct_3)
    );

    // ------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------
    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 15);  // fold high bits into the weak low ones
    endfunction

    function automatic word_t make_instr(opcode_t op, word_t bits);
        return {bits[31:7], op, 2'b11};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;  // outputs settled, safe to sample and drive
    endtask

    task automatic issue(input word_t ins, output word_t used_pc);
        used_pc = next_rand() & 32'hffff_fffc;  // word aligned
        instr   = ins;
        pc      = used_pc;
        next_cycle();
    endtask

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    // {jump, branch, reg_write, mem_write, alu_src, addr_src, fence, result_src}
    function automatic logic [8:0] expected_ctrl(opcode_t op);
        result_src_t res;
        if (op == LOAD) res = RES_MEM;
        else if (op inside {JAL, JALR}) res = RES_PC4;
        else if (op == AUIPC) res = RES_PC_IMM;
        else res = RES_ALU;
        return {op == JAL, op == BRANCH,
                op inside {LUI, AUIPC, JAL, JALR, LOAD, OP_IMM, OP, SYSTEM},
                op == STORE,
                op inside {LUI, AUIPC, JALR, LOAD, STORE, OP_IMM, SYSTEM},
                op == JALR, op == FENCE, res};
    endfunction

    function automatic alu_control_t expected_alu_control(word_t ins);
        logic [2:0] f3;
        logic f75;
        alu_control_t arith [8];
        f3    = ins[14:12];
        f75   = ins[30];
        arith = '{ALUC_ADD, ALUC_SLL, ALUC_SLT, ALUC_SLTU, ALUC_XOR,
                  f75 ? ALUC_SRA : ALUC_SRL, ALUC_OR, ALUC_AND};  // indexed by funct3
        case (ins[6:2])
            OP_IMM: return arith[f3];
            OP:     return (f3 == 3'b000) ? (f75 ? ALUC_SUB : ALUC_ADD) : arith[f3];
            BRANCH: begin
                case (f3)
                    3'b001:  return ALUC_BNE;
                    3'b100:  return ALUC_BLT;
                    3'b101:  return ALUC_BGE;
                    3'b110:  return ALUC_BLTU;
                    3'b111:  return ALUC_BGEU;
                    default: return ALUC_BEQ;
                endcase
            end
            LUI:     return ALUC_LUI;
            default: return ALUC_ADD;
        endcase
    endfunction

    function automatic word_t sign_extend(word_t field, int bits);
        word_t up;
        up = field << (32 - bits);  // field msb up to bit 31
        return word_t'($signed(up) >>> (32 - bits));
    endfunction

    function automatic word_t expected_imm(word_t ins);
        case (ins[6:2])
            LUI, AUIPC: return {ins[31:12], 12'h000};
            JAL:     return sign_extend({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}, 21);
            BRANCH:  return sign_extend({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}, 13);
            STORE:   return sign_extend({ins[31:25], ins[11:7]}, 12);
            default: return sign_extend(ins[31:20], 12);
        endcase
    endfunction

    // ------------------------------------------------------------------
    // checking
    // ------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "first mismatch seen on %s, run stopped", name);
        end
    endtask

    task automatic compare_outputs(input logic [8:0] ctl, input alu_control_t aluc,
                                   input word_t rd1, input word_t rd2, input word_t imm,
                                   input word_t at_pc, input reg_addr_t rd,
                                   input logic [2:0] f3);
        check_value("o_jump_EX", ctl[8], ex_jump);
        check_value("o_branch_EX", ctl[7], ex_branch);
        check_value("o_reg_write_EX", ctl[6], ex_reg_write);
        check_value("o_mem_write_EX", ctl[5], ex_mem_write);
        check_value("o_alu_src_EX", ctl[4], ex_alu_src);
        check_value("o_addr_src_EX", ctl[3], ex_addr_src);
        check_value("o_fence_EX", ctl[2], ex_fence);
        check_value("o_result_src_EX", ctl[1:0], ex_result_src);
        check_value("o_alu_control_EX", aluc, ex_alu_control);
        check_value("o_rd1_EX", rd1, ex_rd1);
        check_value("o_rd2_EX", rd2, ex_rd2);
        check_value("o_imm_ext_EX", imm, ex_imm);
        check_value("o_pc_EX", at_pc, ex_pc);
        check_value("o_rd_EX", rd, ex_rd);
        check_value("o_funct_3_EX", f3, ex_funct_3);
    endtask

    // full pipeline entry predicted from the instruction
    task automatic expect_entry(input word_t ins, input word_t at_pc);
        compare_outputs(expected_ctrl(ins[6:2]), expected_alu_control(ins),
                        ref_regs[ins[19:15]], ref_regs[ins[24:20]], expected_imm(ins),
                        at_pc, ins[11:7], ins[14:12]);
    endtask

    task automatic expect_bubble();
        compare_outputs('0, '0, '0, '0, '0, '0, '0, '0);
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    task automatic verify_reset();
        expect_bubble();  // nothing issued yet
    endtask

    task automatic sweep_opcodes();
        word_t ins, p;
        foreach (ALL_OPS[k]) begin
            repeat (4) begin
                ins = make_instr(ALL_OPS[k], next_rand());
                issue(ins, p);
                expect_entry(ins, p);
            end
        end
    endtask

    task automatic sweep_alu_codes();
        opcode_t coded [3] = '{OP, OP_IMM, BRANCH};
        opcode_t plain [7] = '{LUI, AUIPC, JALR, LOAD, STORE, FENCE, SYSTEM};
        word_t ins, p;
        foreach (coded[k]) begin
            for (int f = 0; f < 16; f++) begin
                ins        = make_instr(coded[k], next_rand());
                ins[14:12] = f[2:0];
                ins[30]    = f[3];  // funct7 bit 5
                issue(ins, p);
                expect_entry(ins, p);
            end
        end
        foreach (plain[k]) begin
            ins = make_instr(plain[k], next_rand());
            issue(ins, p);
            expect_entry(ins, p);
        end
    endtask

    task automatic random_immediates();
        opcode_t fmt_ops [5] = '{OP_IMM, STORE, BRANCH, JAL, AUIPC};  // I, S, B, J, U
        word_t ins, p;
        foreach (fmt_ops[k]) begin
            repeat (200) begin
                ins = make_instr(fmt_ops[k], next_rand());
                issue(ins, p);
                expect_entry(ins, p);
            end
        end
    endtask

    task automatic exercise_regfile();
        reg_addr_t rd;
        word_t ins, p;
        // each write is read on rs1 in the same cycle, bypass path
        repeat (40) begin
            rd          = reg_addr_t'(1 + next_rand() % 31);
            ins         = make_instr(OP, next_rand());
            ins[19:15]  = rd;
            wb_we       = 1'b1;
            wb_rd       = rd;
            wb_data     = next_rand();
            ref_regs[rd] = wb_data;
            issue(ins, p);
            wb_we = 1'b0;
            expect_entry(ins, p);
        end
        // x0 write is dropped
        ins        = make_instr(OP, next_rand());
        ins[19:15] = '0;
        ins[24:20] = '0;
        wb_we      = 1'b1;
        wb_rd      = '0;
        wb_data    = next_rand() | 32'h1;
        issue(ins, p);
        wb_we = 1'b0;
        expect_entry(ins, p);
        // read back the whole file, x0 included
        for (int r = 0; r < 32; r++) begin
            ins        = make_instr(OP, next_rand());
            ins[19:15] = reg_addr_t'(r);
            ins[24:20] = reg_addr_t'(31 - r);
            issue(ins, p);
            expect_entry(ins, p);
        end
    endtask

    task automatic stall_flush_sequence();
        word_t ins_a, pc_a, ins, p;
        ins_a = make_instr(BRANCH, next_rand());
        issue(ins_a, pc_a);
        expect_entry(ins_a, pc_a);
        stall = 1'b1;
        repeat (3) begin
            issue(make_instr(OP, next_rand()), p);
            expect_entry(ins_a, pc_a);  // held while the instruction changes
        end
        flush = 1'b1;  // flush wins over stall
        issue(make_instr(STORE, next_rand()), p);
        expect_bubble();
        stall = 1'b0;
        issue(make_instr(JAL, next_rand()), p);
        expect_bubble();
        flush = 1'b0;
        ins = make_instr(LOAD, next_rand());
        issue(ins, p);
        expect_entry(ins, p);
    endtask

    // ------------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------------
    initial begin
        lcg_state = 32'h552d_fed9;
        instr     = '0;
        pc        = '0;
        stall     = 1'b0;
        flush     = 1'b0;
        wb_we     = 1'b0;
        wb_rd     = '0;
        wb_data   = '0;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        @(negedge reset);  // lands 1 ns after an edge
        verify_reset();
        sweep_opcodes();
        sweep_alu_codes();
        random_immediates();
        exercise_regfile();
        stall_flush_sequence();
        $display("All checks passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Checks failed");
        $fatal(1, "timeout, tests did not finish within %0d ns", TIMEOUT_NS);
    end

endmodule

//--- osiris_decode.f
design/osiris_decode_pkg.sv
design/op_decoder.sv
design/alu_decoder.sv
design/imm_extend.sv
design/register_file.sv
design/id_ex_register.sv
design/decode_stage.sv
dv/clock_gen.sv
dv/tb_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
# build the decode stage testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_decode_stage \
    -f osiris_decode.f -o sim_decode_stage \
    || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/sim_decode_stage 2>&1)
echo "$out"
echo "$out" | grep -q "^All checks passed$" && exit 0 || exit 1
